//--- src/iomem_pkg.sv
`default_nettype none

package iomem_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // One request on the iomem bus, held by the master until ready
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;  // Any nonzero strobe makes it a write
  } iomem_req_t;

  typedef struct packed {
    logic              ready;
    logic [DATA_W-1:0] rdata;
  } iomem_rsp_t;

  // SRAM window, 4 KiB at this depth
  localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h4000_0000;
  localparam int SRAM_WORDS = 1024;
  localparam int SRAM_AW = $clog2(SRAM_WORDS);

  // PWM register window
  localparam logic [ADDR_W-1:0] PWM_BASE = 32'h2000_0000;
  localparam int PWM_OFS_W = 4;
  localparam logic [PWM_OFS_W-1:0] PWM_CTRL_OFS = 4'h0;    // Bit 0 enables ch0, bit 1 ch1
  localparam logic [PWM_OFS_W-1:0] PWM_PERIOD_OFS = 4'h4;
  localparam logic [PWM_OFS_W-1:0] PWM_DUTY0_OFS = 4'h8;
  localparam logic [PWM_OFS_W-1:0] PWM_DUTY1_OFS = 4'hC;
  localparam int PWM_CNT_W = 16;

  // Wait states for an SRAM access and the width of the counter that times them
  localparam int SRAM_WAIT = 2;
  localparam int WAIT_CNT_W = $clog2(SRAM_WAIT + 1);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    RESP
  } access_state_t;

  typedef enum logic [1:0] {
    TGT_SRAM,
    TGT_PWM,
    TGT_NONE
  } target_t;

endpackage

`default_nettype wire

//--- src/wait_timer.sv
`timescale 1ns/100ps
`default_nettype none

module wait_timer (
  input  logic clk,
  input  logic resetn,
  input  logic load_i,
  output logic done_o
);

  import iomem_pkg::*;

  logic [WAIT_CNT_W-1:0] cnt_q;

  // Loaded with one less than the wait count, so done shows in the last wait cycle
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= WAIT_CNT_W'(SRAM_WAIT - 1);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign done_o = (cnt_q == '0);  // Holds high at zero until the next load

endmodule

`default_nettype wire

//--- src/sram_bank.sv
`timescale 1ns/100ps
`default_nettype none

module sram_bank (
  input  logic                           clk,
  input  logic                           we_i,
  input  logic [iomem_pkg::SRAM_AW-1:0]  addr_i,
  input  logic [iomem_pkg::STRB_W-1:0]   wstrb_i,
  input  logic [iomem_pkg::DATA_W-1:0]   wdata_i,
  output logic [iomem_pkg::DATA_W-1:0]   rdata_o
);

  import iomem_pkg::*;

  logic [DATA_W-1:0] mem_q [SRAM_WORDS];
  logic [DATA_W-1:0] rdata_q;

  // One enable per byte lane
  always_ff @(posedge clk) begin
    for (int i = 0; i < STRB_W; i++) begin
      if (we_i && wstrb_i[i]) begin
        mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
      end
    end
  end

  // The addressed word is read every cycle, old data on a same-edge write
  always_ff @(posedge clk) begin
    rdata_q <= mem_q[addr_i];
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- src/pwm_timebase.sv
`timescale 1ns/100ps
`default_nettype none

module pwm_timebase (
  input  logic                            clk,
  input  logic                            resetn,
  input  logic [iomem_pkg::PWM_CNT_W-1:0] period_i,
  input  logic                            run_i,
  output logic [iomem_pkg::PWM_CNT_W-1:0] count_o,
  output logic                            wrap_o
);

  import iomem_pkg::*;

  logic [PWM_CNT_W-1:0] count_q;
  logic                 active;
  logic                 at_end;

  assign active = run_i && (period_i != '0);

  // A shorter period written mid-count still wraps at once
  assign at_end = (count_q >= period_i - 1'b1);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      count_q <= '0;
    end else if (active) begin
      if (at_end) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end else begin
      count_q <= '0;  // Parked at zero while stopped
    end
  end

  assign count_o = count_q;
  assign wrap_o = active && at_end;  // Same edge as the return to zero

endmodule

`default_nettype wire

//--- src/pwm_regs.sv
`timescale 1ns/100ps
`default_nettype none

module pwm_regs (
  input  logic                            clk,
  input  logic                            resetn,
  input  logic                            we_i,
  input  logic                            re_i,
  input  logic [iomem_pkg::PWM_OFS_W-1:0] ofs_i,
  input  logic [iomem_pkg::DATA_W-1:0]    wdata_i,
  output logic [iomem_pkg::DATA_W-1:0]    rdata_o,
  input  logic [iomem_pkg::PWM_CNT_W-1:0] count_i,
  input  logic                            wrap_i,
  output logic [iomem_pkg::PWM_CNT_W-1:0] period_o,
  output logic                            run_o,
  output logic                            pwm0_o,
  output logic                            pwm1_o
);

  import iomem_pkg::*;

  logic [1:0]           ctrl_q;
  logic [1:0]           ctrl_d;
  logic [PWM_CNT_W-1:0] period_q;
  logic [PWM_CNT_W-1:0] duty0_q;
  logic [PWM_CNT_W-1:0] duty1_q;
  logic [PWM_CNT_W-1:0] cmp0_q;
  logic [PWM_CNT_W-1:0] cmp1_q;
  logic [DATA_W-1:0]    rd_val;
  logic [DATA_W-1:0]    rdata_q;
  logic                 pwm0_q;
  logic                 pwm1_q;

  // Outputs follow the new enable in the same edge that writes it
  assign ctrl_d = (we_i && ofs_i == PWM_CTRL_OFS) ? wdata_i[1:0] : ctrl_q;

  always_comb begin
    case (ofs_i)
      PWM_CTRL_OFS:   rd_val = DATA_W'(ctrl_q);
      PWM_PERIOD_OFS: rd_val = DATA_W'(period_q);
      PWM_DUTY0_OFS:  rd_val = DATA_W'(duty0_q);
      PWM_DUTY1_OFS:  rd_val = DATA_W'(duty1_q);
      default:        rd_val = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ctrl_q   <= '0;
      period_q <= '0;
      duty0_q  <= '0;
      duty1_q  <= '0;
      rdata_q  <= '0;
    end else begin
      ctrl_q <= ctrl_d;
      if (we_i && ofs_i == PWM_PERIOD_OFS) period_q <= wdata_i[PWM_CNT_W-1:0];
      if (we_i && ofs_i == PWM_DUTY0_OFS) duty0_q <= wdata_i[PWM_CNT_W-1:0];
      if (we_i && ofs_i == PWM_DUTY1_OFS) duty1_q <= wdata_i[PWM_CNT_W-1:0];
      if (re_i) rdata_q <= rd_val;
    end
  end

  // Compare values move at a wrap, or freely while the timebase is stopped
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cmp0_q <= '0;
      cmp1_q <= '0;
      pwm0_q <= 1'b0;
      pwm1_q <= 1'b0;
    end else begin
      if (wrap_i || !run_o) begin
        cmp0_q <= duty0_q;
        cmp1_q <= duty1_q;
      end
      pwm0_q <= ctrl_d[0] && (count_i < cmp0_q);
      pwm1_q <= ctrl_d[1] && (count_i < cmp1_q);
    end
  end

  assign rdata_o  = rdata_q;
  assign period_o = period_q;
  assign run_o    = |ctrl_q;
  assign pwm0_o   = pwm0_q;
  assign pwm1_o   = pwm1_q;

endmodule

`default_nettype wire

//--- src/iomem_access_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module iomem_access_fsm (
  input  logic                            clk,
  input  logic                            resetn,
  input  iomem_pkg::iomem_req_t           req_i,
  output iomem_pkg::iomem_rsp_t           rsp_o,
  output logic                            timer_load_o,
  input  logic                            timer_done_i,
  output logic                            sram_we_o,
  output logic [iomem_pkg::SRAM_AW-1:0]   sram_addr_o,
  output logic [iomem_pkg::STRB_W-1:0]    sram_wstrb_o,
  output logic [iomem_pkg::DATA_W-1:0]    sram_wdata_o,
  input  logic [iomem_pkg::DATA_W-1:0]    sram_rdata_i,
  output logic                            reg_we_o,
  output logic                            reg_re_o,
  output logic [iomem_pkg::PWM_OFS_W-1:0] reg_ofs_o,
  output logic [iomem_pkg::DATA_W-1:0]    reg_wdata_o,
  input  logic [iomem_pkg::DATA_W-1:0]    reg_rdata_i
);

  import iomem_pkg::*;

  access_state_t       state_q;
  access_state_t       state_d;
  target_t             tgt_q;
  target_t             req_tgt;
  logic [SRAM_AW-1:0]  word_q;
  logic [DATA_W-1:0]   wdata_q;
  logic [STRB_W-1:0]   wstrb_q;
  logic                accept;
  logic                req_write;

  // The SRAM window is SRAM_WORDS words, so its base must be aligned to that size
  function automatic target_t decode_target(input logic [ADDR_W-1:0] addr);
    if (addr[ADDR_W-1:SRAM_AW+2] == SRAM_BASE[ADDR_W-1:SRAM_AW+2]) begin
      return TGT_SRAM;
    end
    if (addr[ADDR_W-1:PWM_OFS_W] == PWM_BASE[ADDR_W-1:PWM_OFS_W]) begin
      return TGT_PWM;
    end
    return TGT_NONE;
  endfunction

  assign req_tgt   = decode_target(req_i.addr);
  assign req_write = |req_i.wstrb;
  assign accept    = (state_q == IDLE) && req_i.valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (req_i.valid) state_d = (req_tgt == TGT_SRAM) ? WAIT : RESP;
      WAIT: if (timer_done_i) state_d = RESP;
      RESP: state_d = IDLE;  // Next request is sampled one cycle later
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q <= IDLE;
      tgt_q   <= TGT_NONE;
    end else begin
      state_q <= state_d;
      if (accept) tgt_q <= req_tgt;
    end
  end

  // Request payload for the SRAM, which is used after IDLE
  always_ff @(posedge clk) begin
    if (accept) begin
      word_q  <= req_i.addr[SRAM_AW+1:2];
      wdata_q <= req_i.wdata;
      wstrb_q <= req_i.wstrb;
    end
  end

  assign timer_load_o = accept && (req_tgt == TGT_SRAM);

  // SRAM write lands on the edge into RESP, the read register captures on that edge too
  assign sram_we_o    = (state_q == WAIT) && timer_done_i && (|wstrb_q);
  assign sram_addr_o  = word_q;
  assign sram_wstrb_o = wstrb_q;
  assign sram_wdata_o = wdata_q;

  // PWM registers are accessed straight from the bus on the edge leaving IDLE
  assign reg_we_o    = accept && (req_tgt == TGT_PWM) && req_write;
  assign reg_re_o    = accept && (req_tgt == TGT_PWM) && !req_write;
  assign reg_ofs_o   = req_i.addr[PWM_OFS_W-1:0];
  assign reg_wdata_o = req_i.wdata;

  always_comb begin
    rsp_o.ready = (state_q == RESP);
    rsp_o.rdata = '0;
    if (state_q == RESP) begin
      case (tgt_q)
        TGT_SRAM: rsp_o.rdata = sram_rdata_i;
        TGT_PWM:  rsp_o.rdata = reg_rdata_i;
        default:  rsp_o.rdata = '0;  // Unmapped reads return zero
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/iomem_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module iomem_subsys_top (
  input  logic                  clk,
  input  logic                  resetn,
  input  iomem_pkg::iomem_req_t iomem_req_i,
  output iomem_pkg::iomem_rsp_t iomem_rsp_o,
  output logic                  pwm0_o,
  output logic                  pwm1_o
);

  import iomem_pkg::*;

  logic                 timer_load;
  logic                 timer_done;
  logic                 sram_we;
  logic [SRAM_AW-1:0]   sram_addr;
  logic [STRB_W-1:0]    sram_wstrb;
  logic [DATA_W-1:0]    sram_wdata;
  logic [DATA_W-1:0]    sram_rdata;
  logic                 reg_we;
  logic                 reg_re;
  logic [PWM_OFS_W-1:0] reg_ofs;
  logic [DATA_W-1:0]    reg_wdata;
  logic [DATA_W-1:0]    reg_rdata;
  logic [PWM_CNT_W-1:0] pwm_period;
  logic [PWM_CNT_W-1:0] pwm_count;
  logic                 pwm_run;
  logic                 pwm_wrap;

  iomem_access_fsm u_fsm (
    .clk          (clk),
    .resetn       (resetn),
    .req_i        (iomem_req_i),
    .rsp_o        (iomem_rsp_o),
    .timer_load_o (timer_load),
    .timer_done_i (timer_done),
    .sram_we_o    (sram_we),
    .sram_addr_o  (sram_addr),
    .sram_wstrb_o (sram_wstrb),
    .sram_wdata_o (sram_wdata),
    .sram_rdata_i (sram_rdata),
    .reg_we_o     (reg_we),
    .reg_re_o     (reg_re),
    .reg_ofs_o    (reg_ofs),
    .reg_wdata_o  (reg_wdata),
    .reg_rdata_i  (reg_rdata)
  );

  wait_timer u_wait_timer (
    .clk    (clk),
    .resetn (resetn),
    .load_i (timer_load),
    .done_o (timer_done)
  );

  sram_bank u_sram (
    .clk     (clk),
    .we_i    (sram_we),
    .addr_i  (sram_addr),
    .wstrb_i (sram_wstrb),
    .wdata_i (sram_wdata),
    .rdata_o (sram_rdata)
  );

  pwm_timebase u_pwm_timebase (
    .clk      (clk),
    .resetn   (resetn),
    .period_i (pwm_period),
    .run_i    (pwm_run),
    .count_o  (pwm_count),
    .wrap_o   (pwm_wrap)
  );

  pwm_regs u_pwm_regs (
    .clk      (clk),
    .resetn   (resetn),
    .we_i     (reg_we),
    .re_i     (reg_re),
    .ofs_i    (reg_ofs),
    .wdata_i  (reg_wdata),
    .rdata_o  (reg_rdata),
    .count_i  (pwm_count),
    .wrap_i   (pwm_wrap),
    .period_o (pwm_period),
    .run_o    (pwm_run),
    .pwm0_o   (pwm0_o),
    .pwm1_o   (pwm1_o)
  );

endmodule

`default_nettype wire

//--- verification/iomem_subsys_assert.sv
`timescale 1ns/100ps
`default_nettype none

module iomem_subsys_assert (
  input  logic                  clk,
  input  logic                  resetn,
  input  iomem_pkg::iomem_req_t req_i,
  input  iomem_pkg::iomem_rsp_t rsp_i,
  input  logic                  pwm0_i,
  input  logic                  pwm1_i
);

  import iomem_pkg::*;

  int         fail_cnt = 0;
  logic       pending_q;
  logic [1:0] enable_q;
  logic       accept;
  logic       to_sram;
  logic       to_pwm;
  logic       ctrl_write;

  assign accept     = req_i.valid && !pending_q;  // Busy from acceptance until ready
  assign to_sram    = (req_i.addr >= SRAM_BASE) && (req_i.addr < SRAM_BASE + 4 * SRAM_WORDS);
  assign to_pwm     = (req_i.addr >= PWM_BASE) && (req_i.addr < PWM_BASE + 16);
  assign ctrl_write = accept && to_pwm && (|req_i.wstrb) &&
                      (req_i.addr[PWM_OFS_W-1:0] == PWM_CTRL_OFS);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      pending_q <= 1'b0;
      enable_q  <= '0;
    end else begin
      if (accept) begin
        pending_q <= 1'b1;
      end else if (rsp_i.ready) begin
        pending_q <= 1'b0;
      end
      if (ctrl_write) enable_q <= req_i.wdata[1:0];  // Enable bits as last written
    end
  end

  ready_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
    $rose(rsp_i.ready) |-> req_i.valid)
    else begin
      fail_cnt++;
      $error("ready rose while valid was low");
    end

  ready_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
    rsp_i.ready |=> !rsp_i.ready)
    else begin
      fail_cnt++;
      $error("ready stayed high for more than one cycle");
    end

  sram_latency: assert property (@(posedge clk) disable iff (!resetn)
    accept && to_sram |-> ##1 !rsp_i.ready ##1 !rsp_i.ready ##1 rsp_i.ready)
    else begin
      fail_cnt++;
      $error("SRAM access did not complete after exactly 3 cycles");
    end

  other_latency: assert property (@(posedge clk) disable iff (!resetn)
    accept && !to_sram |-> ##1 rsp_i.ready)
    else begin
      fail_cnt++;
      $error("PWM or unmapped access did not complete after 1 cycle");
    end

  pwm0_off: assert property (@(posedge clk) disable iff (!resetn)
    !enable_q[0] |-> !pwm0_i)
    else begin
      fail_cnt++;
      $error("pwm0 high while channel 0 is disabled");
    end

  pwm1_off: assert property (@(posedge clk) disable iff (!resetn)
    !enable_q[1] |-> !pwm1_i)
    else begin
      fail_cnt++;
      $error("pwm1 high while channel 1 is disabled");
    end

endmodule

`default_nettype wire

//--- verification/tb_iomem_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_iomem_subsys;

  import iomem_pkg::*;

  localparam int READY_TIMEOUT = 20;
  localparam int N_WORDS = 16;
  localparam int PWM_PERIOD = 10;
  localparam int SRAM_LAT = 1 + SRAM_WAIT;
  localparam int REG_LAT = 1;

  logic        clk;
  logic        resetn;
  iomem_req_t  req;
  iomem_rsp_t  rsp;
  logic        pwm0;
  logic        pwm1;
  int          value_errors;
  int          timeout_errors;
  int          seed;
  logic [31:0] ref_mem [SRAM_WORDS];
  int          word_list [N_WORDS];

  iomem_subsys_top DUT (
    .clk         (clk),
    .resetn      (resetn),
    .iomem_req_i (req),
    .iomem_rsp_o (rsp),
    .pwm0_o      (pwm0),
    .pwm1_o      (pwm1)
  );

  bind iomem_subsys_top iomem_subsys_assert u_assert (
    .clk    (clk),
    .resetn (resetn),
    .req_i  (iomem_req_i),
    .rsp_i  (iomem_rsp_o),
    .pwm0_i (pwm0_o),
    .pwm1_i (pwm1_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] sram_addr(input int word);
    return SRAM_BASE + (32'(word) << 2);
  endfunction

  function automatic logic [31:0] pwm_addr(input logic [PWM_OFS_W-1:0] ofs);
    return PWM_BASE + 32'(ofs);
  endfunction

  // Byte lanes with a set strobe take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) result[8*i +: 8] = new_word[8*i +: 8];
    end
    return result;
  endfunction

  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      value_errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Called 1 ns after an edge, returns 1 ns after the edge that follows ready
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata,
                            output int latency);
    logic got_ready;
    got_ready = 1'b0;
    latency = 0;
    rdata = '0;
    req.valid = 1'b1;
    req.addr = addr;
    req.wdata = wdata;
    req.wstrb = wstrb;
    while (!got_ready && latency < READY_TIMEOUT) begin
      @(posedge clk);
      #1;
      latency++;
      got_ready = rsp.ready;
    end
    if (got_ready) begin
      rdata = rsp.rdata;
    end else begin
      timeout_errors++;
      $display("Timeout: no ready within %0d cycles for address %h", READY_TIMEOUT, addr);
    end
    @(posedge clk);
    #1;
    req.valid = 1'b0;
    req.wstrb = '0;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int exp_lat);
    logic [31:0] rdata;
    int          lat;
    bus_access(addr, data, strb, rdata, lat);
    check_equal("write latency", 32'(exp_lat), 32'(lat));
  endtask

  task automatic read_check(input string name, input logic [31:0] addr,
                            input logic [31:0] exp, input int exp_lat);
    logic [31:0] rdata;
    int          lat;
    bus_access(addr, 32'h0, 4'h0, rdata, lat);
    check_equal(name, exp, rdata);
    check_equal({name, " latency"}, 32'(exp_lat), 32'(lat));
  endtask

  task automatic measure_high(output int high0, output int high1);
    high0 = 0;
    high1 = 0;
    repeat (PWM_PERIOD) begin
      @(posedge clk);
      #1;
      if (pwm0) high0++;
      if (pwm1) high1++;
    end
  endtask

  task automatic check_duty(input string name, input int exp0, input int exp1);
    int high0;
    int high1;
    wait_cycles(2 * PWM_PERIOD);  // New compare values need a wrap
    measure_high(high0, high1);
    check_equal({name, " pwm0 high cycles"}, 32'(exp0), 32'(high0));
    check_equal({name, " pwm1 high cycles"}, 32'(exp1), 32'(high1));
  endtask

  initial begin
    logic [31:0] data;
    logic [3:0]  strb;
    int          word;
    seed = 32'hdba040bc;
    value_errors = 0;
    timeout_errors = 0;
    resetn = 1'b0;
    req = '0;
    repeat (4) @(posedge clk);
    #1;
    resetn = 1'b1;

    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      #1;
      check_equal("reset ready", 32'h0, 32'(rsp.ready));
      check_equal("reset pwm0", 32'h0, 32'(pwm0));
      check_equal("reset pwm1", 32'h0, 32'(pwm1));
    end
    read_check("reset ctrl", pwm_addr(PWM_CTRL_OFS), 32'h0, REG_LAT);
    read_check("reset period", pwm_addr(PWM_PERIOD_OFS), 32'h0, REG_LAT);
    read_check("reset duty0", pwm_addr(PWM_DUTY0_OFS), 32'h0, REG_LAT);
    read_check("reset duty1", pwm_addr(PWM_DUTY1_OFS), 32'h0, REG_LAT);

    // Full words first, so every lane of the reference is known
    for (int i = 0; i < N_WORDS; i++) begin
      word_list[i] = $random(seed) & (SRAM_WORDS - 1);
      data = $random(seed);
      write_word(sram_addr(word_list[i]), data, 4'hF, SRAM_LAT);
      ref_mem[word_list[i]] = data;
    end
    for (int i = 0; i < N_WORDS; i++) begin
      read_check("sram full word", sram_addr(word_list[i]), ref_mem[word_list[i]], SRAM_LAT);
    end

    for (int i = 0; i < N_WORDS; i++) begin
      strb = 4'($random(seed));
      if (strb == 4'h0) strb = 4'h5;
      if (strb == 4'hF) strb = 4'h2;
      data = $random(seed);
      write_word(sram_addr(word_list[i]), data, strb, SRAM_LAT);
      ref_mem[word_list[i]] = merge_bytes(ref_mem[word_list[i]], data, strb);
      read_check("sram byte lanes", sram_addr(word_list[i]), ref_mem[word_list[i]], SRAM_LAT);
    end

    write_word(pwm_addr(PWM_PERIOD_OFS), 32'hFFFF_1234, 4'hF, REG_LAT);  // Upper half dropped
    write_word(pwm_addr(PWM_DUTY0_OFS), 32'h0000_0055, 4'hF, REG_LAT);
    write_word(pwm_addr(PWM_DUTY1_OFS), 32'hABCD_0066, 4'hF, REG_LAT);
    read_check("period readback", pwm_addr(PWM_PERIOD_OFS), 32'h0000_1234, REG_LAT);
    read_check("duty0 readback", pwm_addr(PWM_DUTY0_OFS), 32'h0000_0055, REG_LAT);
    read_check("duty1 readback", pwm_addr(PWM_DUTY1_OFS), 32'h0000_0066, REG_LAT);
    read_check("ctrl readback", pwm_addr(PWM_CTRL_OFS), 32'h0, REG_LAT);
    write_word(32'h3000_0000, 32'hDEAD_BEEF, 4'hF, REG_LAT);
    read_check("unmapped read", 32'h3000_0000, 32'h0, REG_LAT);
    read_check("unmapped pwm gap", PWM_BASE + 32'h10, 32'h0, REG_LAT);

    write_word(pwm_addr(PWM_PERIOD_OFS), 32'(PWM_PERIOD), 4'hF, REG_LAT);
    write_word(pwm_addr(PWM_DUTY0_OFS), 32'd3, 4'hF, REG_LAT);
    write_word(pwm_addr(PWM_DUTY1_OFS), 32'd7, 4'hF, REG_LAT);
    write_word(pwm_addr(PWM_CTRL_OFS), 32'h3, 4'hF, REG_LAT);
    read_check("ctrl enabled readback", pwm_addr(PWM_CTRL_OFS), 32'h3, REG_LAT);
    check_duty("both enabled", 3, 7);
    write_word(pwm_addr(PWM_CTRL_OFS), 32'h1, 4'hF, REG_LAT);
    check_duty("ch1 disabled", 3, 0);
    write_word(pwm_addr(PWM_DUTY0_OFS), 32'd5, 4'hF, REG_LAT);
    check_duty("duty0 update", 5, 0);
    write_word(pwm_addr(PWM_CTRL_OFS), 32'h0, 4'hF, REG_LAT);
    check_duty("all disabled", 0, 0);

    // Each request starts in the cycle after the previous ready
    for (int i = 0; i < 8; i++) begin
      word = word_list[i];
      data = $random(seed);
      write_word(sram_addr(word), data, 4'hF, SRAM_LAT);
      ref_mem[word] = data;
      read_check("b2b pwm", pwm_addr(PWM_DUTY0_OFS), 32'd5, REG_LAT);
      read_check("b2b sram", sram_addr(word), ref_mem[word], SRAM_LAT);
      read_check("b2b unmapped", 32'h0000_1000 + (32'(i) << 2), 32'h0, REG_LAT);
    end

    wait_cycles(4);
    $display("Errors: %0d value, %0d timeout, %0d assertion",
             value_errors, timeout_errors, DUT.u_assert.fail_cnt);
    if (value_errors + timeout_errors + DUT.u_assert.fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
src/iomem_pkg.sv
src/wait_timer.sv
src/sram_bank.sv
src/pwm_timebase.sv
src/pwm_regs.sv
src/iomem_access_fsm.sv
src/iomem_subsys_top.sv
verification/iomem_subsys_assert.sv
verification/tb_iomem_subsys.sv

//--- Bender.yml
package:
  name: iomem_subsys

sources:
  - src/iomem_pkg.sv
  - src/wait_timer.sv
  - src/sram_bank.sv
  - src/pwm_timebase.sv
  - src/pwm_regs.sv
  - src/iomem_access_fsm.sv
  - src/iomem_subsys_top.sv
  - target: test
    files:
      - verification/iomem_subsys_assert.sv
      - verification/tb_iomem_subsys.sv
